//--- design/fma_pkg.sv
/*
 * Binary16 FMA package with format constants, datapath widths,
 * operand class, operation and status types, canonical NaN
 */
`default_nettype none

package fma_pkg;

  // ----------------------------------------------------------
  // Format and datapath constants
  // ----------------------------------------------------------
  localparam int EXP_BITS = 5;
  localparam int MAN_BITS = 10;
  localparam int BIAS     = 15;
  localparam int WIDTH    = 1 + EXP_BITS + MAN_BITS;

  localparam int PREC_BITS       = MAN_BITS + 1;              // Implicit bit included
  localparam int EXP_WIDTH       = EXP_BITS + 2;              // Signed, holds product range
  localparam int SUM_WIDTH       = 3 * PREC_BITS + 4;         // Aligned adder incl. G/R
  localparam int LOWER_SUM_WIDTH = 2 * PREC_BITS + 3;         // Part searched for leading zeros
  localparam int LZC_WIDTH       = $clog2(LOWER_SUM_WIDTH);
  localparam int SHIFT_WIDTH     = $clog2(SUM_WIDTH + 1);     // Shift up to 3p+4

  typedef struct packed {
    logic                sign;
    logic [EXP_BITS-1:0] exponent;
    logic [MAN_BITS-1:0] mantissa;
  } fp_t;

  // Signalling is a sub-class of nan
  typedef struct packed {
    logic is_normal;
    logic is_subnormal;
    logic is_zero;
    logic is_inf;
    logic is_nan;
    logic is_signalling;
  } fp_info_t;

  typedef enum logic [1:0] {FMADD, FNMSUB, ADD, MUL} op_e;

  typedef struct packed {
    logic NV;  // Invalid operation
    logic OF;  // Overflow
    logic UF;  // Underflow
    logic NX;  // Inexact
  } status_t;

  localparam logic [WIDTH-1:0] QNAN = 16'h7E00;  // Canonical quiet NaN

endpackage

`default_nettype wire

//--- design/fma_operand_prep.sv
/*
 * Operand classification and operation-dependent operand adjustment
 */
`default_nettype none
`timescale 1ns/1ps

module fma_operand_prep import fma_pkg::*; (
  input  fp_t [2:0] operands_i,   // c, b, a from MSB down
  input  op_e       op_i,
  input  logic      op_mod_i,     // Inverts addend sign
  output fp_t       operand_a_o,
  output fp_t       operand_b_o,
  output fp_t       operand_c_o,
  output fp_info_t  info_a_o,
  output fp_info_t  info_b_o,
  output fp_info_t  info_c_o
);

  fp_info_t [2:0] info;

  function automatic fp_info_t classify(input fp_t value);
    fp_info_t cls;
    logic     exp_zero;
    logic     exp_ones;
    logic     man_zero;
    exp_zero          = (value.exponent == '0);
    exp_ones          = (&value.exponent);
    man_zero          = (value.mantissa == '0);
    cls.is_normal     = !exp_zero && !exp_ones;
    cls.is_subnormal  = exp_zero && !man_zero;
    cls.is_zero       = exp_zero && man_zero;
    cls.is_inf        = exp_ones && man_zero;
    cls.is_nan        = exp_ones && !man_zero;
    cls.is_signalling = cls.is_nan && !value.mantissa[MAN_BITS-1];  // Quiet bit clear
    return cls;
  endfunction

  always_comb begin : classify_ops
    for (int i = 0; i < 3; i++) begin
      info[i] = classify(operands_i[i]);
    end
  end

  // FMADD none, FNMSUB negates a, ADD sets a to +1.0, MUL sets c to -0
  always_comb begin : op_select
    operand_a_o      = operands_i[0];
    operand_b_o      = operands_i[1];
    operand_c_o      = operands_i[2];
    info_a_o         = info[0];
    info_b_o         = info[1];
    info_c_o         = info[2];
    operand_c_o.sign = operands_i[2].sign ^ op_mod_i;  // Gives FMSUB, FNMADD, SUB
    unique case (op_i)
      FMADD:  ;  // Operands unchanged
      FNMSUB: operand_a_o.sign = ~operands_i[0].sign;
      ADD: begin
        operand_a_o = '{sign: 1'b0, exponent: EXP_BITS'(BIAS), mantissa: '0};
        info_a_o    = '{is_normal: 1'b1, default: 1'b0};
      end
      MUL: begin
        operand_c_o = '{sign: 1'b1, exponent: '0, mantissa: '0};  // -0 keeps +0 products exact
        info_c_o    = '{is_zero: 1'b1, default: 1'b0};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- design/fma_product_path.sv
/*
 * Mantissa multiplier and biased product exponent
 */
`default_nettype none
`timescale 1ns/1ps

module fma_product_path import fma_pkg::*; (
  input  fp_t                         operand_a_i,
  input  fp_t                         operand_b_i,
  input  fp_info_t                    info_a_i,
  input  fp_info_t                    info_b_i,
  output logic [SUM_WIDTH-1:0]        product_shifted_o,
  output logic signed [EXP_WIDTH-1:0] exponent_product_o,
  output logic                        tentative_sign_o
);

  logic [PREC_BITS-1:0]   mantissa_a, mantissa_b;
  logic [2*PREC_BITS-1:0] product;
  logic [EXP_WIDTH-1:0]   exponent_a, exponent_b;

  assign mantissa_a = {info_a_i.is_normal, operand_a_i.mantissa};  // Restore implicit bit
  assign mantissa_b = {info_b_i.is_normal, operand_b_i.mantissa};
  assign product    = mantissa_a * mantissa_b;

  // Layout | 0 (p+2) | product (2p) | RS |
  assign product_shifted_o = SUM_WIDTH'(product) << 2;

  // Subnormals count as encoded exponent 1
  assign exponent_a = EXP_WIDTH'(operand_a_i.exponent) + EXP_WIDTH'(info_a_i.is_subnormal);
  assign exponent_b = EXP_WIDTH'(operand_b_i.exponent) + EXP_WIDTH'(info_b_i.is_subnormal);

  assign exponent_product_o = (info_a_i.is_zero || info_b_i.is_zero)
                              ? EXP_WIDTH'(2 - BIAS)                     // Minimum exponent
                              : exponent_a + exponent_b - EXP_WIDTH'(BIAS);
  assign tentative_sign_o   = operand_a_i.sign ^ operand_b_i.sign;      // Product sign

endmodule

`default_nettype wire

//--- design/fma_addend_align.sv
/*
 * Addend alignment against the product, sticky collection and
 * inversion for effective subtraction
 */
`default_nettype none
`timescale 1ns/1ps

module fma_addend_align import fma_pkg::*; (
  input  fp_t                         operand_c_i,
  input  fp_info_t                    info_c_i,
  input  logic signed [EXP_WIDTH-1:0] exponent_product_i,
  input  logic                        product_sign_i,
  output logic [SUM_WIDTH-1:0]        addend_shifted_o,
  output logic [SHIFT_WIDTH-1:0]      addend_shamt_o,
  output logic signed [EXP_WIDTH-1:0] exponent_difference_o,
  output logic signed [EXP_WIDTH-1:0] tentative_exponent_o,
  output logic                        sticky_before_add_o,
  output logic                        inject_carry_o,
  output logic                        effective_sub_o
);

  logic signed [EXP_WIDTH-1:0]    exponent_addend;
  logic [SUM_WIDTH+PREC_BITS-1:0] addend_wide;   // Kept bits plus up to p sticky bits
  logic [SUM_WIDTH-1:0]           addend_after_shift;

  assign effective_sub_o       = product_sign_i ^ operand_c_i.sign;
  assign exponent_addend       = EXP_WIDTH'(operand_c_i.exponent) + EXP_WIDTH'(!info_c_i.is_normal);
  assign exponent_difference_o = exponent_addend - exponent_product_i;
  assign tentative_exponent_o  = (exponent_difference_o > 0) ? exponent_addend : exponent_product_i;

  always_comb begin : shift_amount
    if (exponent_difference_o <= -2 * PREC_BITS - 1) begin
      addend_shamt_o = SHIFT_WIDTH'(SUM_WIDTH);  // Product-anchored, addend only sticky
    end else if (exponent_difference_o <= PREC_BITS + 2) begin
      addend_shamt_o = SHIFT_WIDTH'(PREC_BITS + 3 - exponent_difference_o);  // Overlap
    end else begin
      addend_shamt_o = '0;  // Addend-anchored
    end
  end

  // ----------------------------------------------------------
  // Shift, sticky and inversion
  // ----------------------------------------------------------
  assign addend_wide = {{info_c_i.is_normal, operand_c_i.mantissa}, {SUM_WIDTH{1'b0}}}
                       >> addend_shamt_o;
  assign addend_after_shift  = addend_wide[SUM_WIDTH+PREC_BITS-1:PREC_BITS];
  assign sticky_before_add_o = |addend_wide[PREC_BITS-1:0];
  assign addend_shifted_o    = effective_sub_o ? ~addend_after_shift : addend_after_shift;
  assign inject_carry_o      = effective_sub_o & ~sticky_before_add_o;  // Completes 2's compl.

endmodule

`default_nettype wire

//--- design/fma_special_case.sv
/*
 * NaN, infinity and invalid-combination detection with bypass result
 */
`default_nettype none
`timescale 1ns/1ps

module fma_special_case import fma_pkg::*; (
  input  fp_t      operand_a_i,
  input  fp_t      operand_b_i,
  input  fp_t      operand_c_i,
  input  fp_info_t info_a_i,
  input  fp_info_t info_b_i,
  input  fp_info_t info_c_i,
  output logic     result_is_special_o,
  output fp_t      special_result_o,
  output status_t  special_status_o
);

  logic any_nan, any_sig_nan, product_inf, effective_sub;

  assign any_nan       = info_a_i.is_nan | info_b_i.is_nan | info_c_i.is_nan;
  assign any_sig_nan   = info_a_i.is_signalling | info_b_i.is_signalling |
                         info_c_i.is_signalling;
  assign product_inf   = info_a_i.is_inf | info_b_i.is_inf;
  assign effective_sub = operand_a_i.sign ^ operand_b_i.sign ^ operand_c_i.sign;

  always_comb begin : special_rules
    result_is_special_o = 1'b1;
    special_result_o    = QNAN;
    special_status_o    = '0;
    if ((info_a_i.is_inf && info_b_i.is_zero) || (info_a_i.is_zero && info_b_i.is_inf)) begin
      special_status_o.NV = 1'b1;  // inf x 0, even with a quiet NaN addend
    end else if (any_nan) begin
      special_status_o.NV = any_sig_nan;
    end else if (product_inf && info_c_i.is_inf && effective_sub) begin
      special_status_o.NV = 1'b1;  // inf - inf
    end else if (product_inf) begin
      special_result_o    = '{sign: operand_a_i.sign ^ operand_b_i.sign, exponent: '1,
                              mantissa: '0};
      special_status_o.OF = 1'b1;
      special_status_o.NX = 1'b1;
    end else if (info_c_i.is_inf) begin
      special_result_o    = '{sign: operand_c_i.sign, exponent: '1, mantissa: '0};
      special_status_o.OF = 1'b1;
      special_status_o.NX = 1'b1;
    end else begin
      result_is_special_o = 1'b0;  // Regular datapath result
    end
  end

endmodule

`default_nettype wire

//--- design/fma_normalize_round.sv
/*
 * Pipeline stage with valid/ready handshake, followed by the adder,
 * leading-zero normalisation, RNE rounding, flags and result select
 */
`default_nettype none
`timescale 1ns/1ps

module fma_normalize_round import fma_pkg::*; #(
  parameter int TagWidth = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic [SUM_WIDTH-1:0]        product_shifted_i,
  input  logic signed [EXP_WIDTH-1:0] exponent_product_i,
  input  logic                        tentative_sign_i,
  input  logic [SUM_WIDTH-1:0]        addend_shifted_i,
  input  logic [SHIFT_WIDTH-1:0]      addend_shamt_i,
  input  logic signed [EXP_WIDTH-1:0] exponent_difference_i,
  input  logic signed [EXP_WIDTH-1:0] tentative_exponent_i,
  input  logic                        sticky_before_add_i,
  input  logic                        inject_carry_i,
  input  logic                        effective_sub_i,
  input  logic                        result_is_special_i,
  input  fp_t                         special_result_i,
  input  status_t                     special_status_i,
  input  logic [TagWidth-1:0]         tag_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  output fp_t                         result_o,
  output status_t                     status_o,
  output logic [TagWidth-1:0]         tag_o,
  output logic                        out_valid_o,
  input  logic                        out_ready_i
);

  // ----------------------------------------------------------
  // Stage register
  // ----------------------------------------------------------
  logic                        valid_q, eff_sub_q, tent_sign_q, sticky_q, carry_q, special_q;
  logic [SUM_WIDTH-1:0]        product_q, addend_q;
  logic signed [EXP_WIDTH-1:0] exp_prod_q, exp_diff_q, tent_exp_q;
  logic [SHIFT_WIDTH-1:0]      shamt_q;
  fp_t                         special_result_q;
  status_t                     special_status_q;
  logic [TagWidth-1:0]         tag_q;

  assign in_ready_o  = ~valid_q | out_ready_i;  // Empty, or content leaves now
  assign out_valid_o = valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      product_q        <= product_shifted_i;
      addend_q         <= addend_shifted_i;
      exp_prod_q       <= exponent_product_i;
      exp_diff_q       <= exponent_difference_i;
      tent_exp_q       <= tentative_exponent_i;
      shamt_q          <= addend_shamt_i;
      eff_sub_q        <= effective_sub_i;
      tent_sign_q      <= tentative_sign_i;
      sticky_q         <= sticky_before_add_i;
      carry_q          <= inject_carry_i;
      special_q        <= result_is_special_i;
      special_result_q <= special_result_i;
      special_status_q <= special_status_i;
      tag_q            <= tag_i;
    end
  end

  // ----------------------------------------------------------
  // Adder and normalisation
  // ----------------------------------------------------------
  logic [SUM_WIDTH:0]           sum_raw, sum_shifted;
  logic [SUM_WIDTH-1:0]         sum;
  logic                         final_sign, lz_empty;
  logic [LZC_WIDTH-1:0]         lz_count;
  logic signed [LZC_WIDTH:0]    lz_count_sgn;
  logic [SHIFT_WIDTH-1:0]       norm_shamt;
  logic signed [EXP_WIDTH-1:0]  norm_exp, final_exp;
  logic [PREC_BITS:0]           final_man;    // Mantissa with round bit
  logic [LOWER_SUM_WIDTH-1:0]   sum_sticky;

  assign sum_raw = {1'b0, product_q} + {1'b0, addend_q} + (SUM_WIDTH+1)'(carry_q);
  // No carry under subtraction means a negative sum
  assign sum = (eff_sub_q && !sum_raw[SUM_WIDTH]) ? -sum_raw[SUM_WIDTH-1:0]
                                                  : sum_raw[SUM_WIDTH-1:0];
  assign final_sign = eff_sub_q ? (sum_raw[SUM_WIDTH] == tent_sign_q) : tent_sign_q;

  always_comb begin : lzc
    lz_count = '0;
    lz_empty = 1'b1;
    for (int i = 0; i < LOWER_SUM_WIDTH; i++) begin
      if (sum[i]) begin  // Highest set bit wins
        lz_count = LZC_WIDTH'(LOWER_SUM_WIDTH - 1 - i);
        lz_empty = 1'b0;
      end
    end
  end
  assign lz_count_sgn = signed'({1'b0, lz_count});

  always_comb begin : norm_shift
    if ((exp_diff_q <= 0) || (eff_sub_q && (exp_diff_q <= 2))) begin
      if ((exp_prod_q - lz_count_sgn + 1 >= 0) && !lz_empty) begin
        norm_shamt = SHIFT_WIDTH'(PREC_BITS + 2 + lz_count);           // Normal result
        norm_exp   = EXP_WIDTH'(exp_prod_q - lz_count_sgn + 1);
      end else begin
        norm_shamt = SHIFT_WIDTH'(PREC_BITS + 2 + exp_prod_q);         // Subnormal, capped
        norm_exp   = '0;
      end
    end else begin
      norm_shamt = shamt_q;  // Addend-anchored, undo alignment
      norm_exp   = tent_exp_q;
    end
  end

  assign sum_shifted = (SUM_WIDTH+1)'(sum) << norm_shamt;

  always_comb begin : small_norm
    {final_man, sum_sticky} = sum_shifted[SUM_WIDTH-1:0];
    final_exp               = norm_exp;
    if (sum_shifted[SUM_WIDTH]) begin
      {final_man, sum_sticky} = sum_shifted[SUM_WIDTH:1];  // Carry out, shift right
      final_exp               = EXP_WIDTH'(norm_exp + 1);
    end else if (sum_shifted[SUM_WIDTH-1]) begin
      final_exp = norm_exp;  // Already normalised
    end else if (norm_exp > 1) begin
      {final_man, sum_sticky} = {sum_shifted[SUM_WIDTH-2:0], 1'b0};
      final_exp               = EXP_WIDTH'(norm_exp - 1);
    end else begin
      final_exp = '0;        // Stays subnormal
    end
  end

  // ----------------------------------------------------------
  // Rounding, flags and result select
  // ----------------------------------------------------------
  logic                         of_before, of_after, uf_after, result_zero, round_up;
  logic [1:0]                   round_sticky;
  logic [EXP_BITS+MAN_BITS-1:0] pre_round_abs, rounded_abs;
  fp_t                          regular_result;
  status_t                      regular_status;

  assign of_before     = final_exp >= 2**EXP_BITS - 1;
  assign pre_round_abs = of_before ? {EXP_BITS'(2**EXP_BITS - 2), {MAN_BITS{1'b1}}}  // Max normal
                                   : {final_exp[EXP_BITS-1:0], final_man[MAN_BITS:1]};
  assign round_sticky  = of_before ? 2'b11 : {final_man[0], (|sum_sticky) | sticky_q};

  assign round_up    = round_sticky[1] & (round_sticky[0] | pre_round_abs[0]);  // Ties to even
  assign rounded_abs = pre_round_abs + (EXP_BITS+MAN_BITS)'(round_up);
  assign result_zero = (pre_round_abs == '0) && (round_sticky == 2'b00);
  assign uf_after    = rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS] == '0;
  assign of_after    = &rounded_abs[EXP_BITS+MAN_BITS-1:MAN_BITS];

  // Exact cancellation gives +0
  assign regular_result = {(result_zero && eff_sub_q) ? 1'b0 : final_sign, rounded_abs};
  assign regular_status = '{NV: 1'b0,
                            OF: of_before | of_after,
                            UF: uf_after & ~result_zero,
                            NX: (|round_sticky) | of_before | of_after};

  assign result_o = special_q ? special_result_q : regular_result;
  assign status_o = special_q ? special_status_q : regular_status;
  assign tag_o    = tag_q;

  // Held item must not change under back-pressure
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(result_o) && $stable(status_o)
                                    && $stable(tag_o))
    else $error("output payload changed while stalled");

endmodule

`default_nettype wire

//--- design/fma_unit.sv
/*
 * Binary16 FMA top level with one pipeline stage
 */
`default_nettype none
`timescale 1ns/1ps

module fma_unit import fma_pkg::*; #(
  parameter int TagWidth = 4
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  fp_t [2:0]           operands_i,
  input  op_e                 op_i,
  input  logic                op_mod_i,
  input  logic [TagWidth-1:0] tag_i,
  input  logic                in_valid_i,
  output logic                in_ready_o,
  output fp_t                 result_o,
  output status_t             status_o,
  output logic [TagWidth-1:0] tag_o,
  output logic                out_valid_o,
  input  logic                out_ready_i
);

  fp_t                         operand_a, operand_b, operand_c, special_result;
  fp_info_t                    info_a, info_b, info_c;
  logic [SUM_WIDTH-1:0]        product_shifted, addend_shifted;
  logic signed [EXP_WIDTH-1:0] exponent_product, exponent_difference, tentative_exponent;
  logic [SHIFT_WIDTH-1:0]      addend_shamt;
  logic                        tentative_sign, sticky_before_add, inject_carry, effective_sub;
  logic                        result_is_special;
  status_t                     special_status;

  fma_operand_prep u_prep (
    .operands_i, .op_i, .op_mod_i,
    .operand_a_o (operand_a), .operand_b_o (operand_b), .operand_c_o (operand_c),
    .info_a_o    (info_a),    .info_b_o    (info_b),    .info_c_o    (info_c)
  );

  fma_product_path u_product (
    .operand_a_i        (operand_a),       .operand_b_i      (operand_b),
    .info_a_i           (info_a),          .info_b_i         (info_b),
    .product_shifted_o  (product_shifted),
    .exponent_product_o (exponent_product),
    .tentative_sign_o   (tentative_sign)
  );

  fma_addend_align u_align (
    .operand_c_i           (operand_c),           .info_c_i (info_c),
    .exponent_product_i    (exponent_product),    .product_sign_i (tentative_sign),
    .addend_shifted_o      (addend_shifted),      .addend_shamt_o (addend_shamt),
    .exponent_difference_o (exponent_difference),
    .tentative_exponent_o  (tentative_exponent),
    .sticky_before_add_o   (sticky_before_add),   .inject_carry_o (inject_carry),
    .effective_sub_o       (effective_sub)
  );

  fma_special_case u_special (
    .operand_a_i (operand_a), .operand_b_i (operand_b), .operand_c_i (operand_c),
    .info_a_i    (info_a),    .info_b_i    (info_b),    .info_c_i    (info_c),
    .result_is_special_o (result_is_special),
    .special_result_o    (special_result),
    .special_status_o    (special_status)
  );

  fma_normalize_round #(.TagWidth(TagWidth)) u_back_end (
    .clk_i, .rst_n_i,
    .product_shifted_i     (product_shifted),     .exponent_product_i   (exponent_product),
    .tentative_sign_i      (tentative_sign),      .addend_shifted_i     (addend_shifted),
    .addend_shamt_i        (addend_shamt),        .exponent_difference_i (exponent_difference),
    .tentative_exponent_i  (tentative_exponent),  .sticky_before_add_i  (sticky_before_add),
    .inject_carry_i        (inject_carry),        .effective_sub_i      (effective_sub),
    .result_is_special_i   (result_is_special),   .special_result_i     (special_result),
    .special_status_i      (special_status),      .tag_i,
    .in_valid_i, .in_ready_o, .result_o, .status_o, .tag_o, .out_valid_o, .out_ready_i
  );

endmodule

`default_nettype wire

//--- tests/tb_fma_unit.sv
/*
 * Directed testbench for the binary16 FMA unit with clock, reset,
 * integer encoder, compare tasks and handshake tests
 */
`default_nettype none
`timescale 1ns/1ps

module tb_fma_unit import fma_pkg::*; ();

  localparam int TAG_W          = 4;
  localparam int TIMEOUT_CYCLES = 50;  // Per wait loop

  localparam fp_t     POS_INF  = 16'h7C00;
  localparam fp_t     POS_ZERO = 16'h0000;
  localparam status_t ST_NONE  = 4'b0000;
  localparam status_t ST_NV    = 4'b1000;
  localparam status_t ST_OFNX  = 4'b0101;  // Overflow is always inexact
  localparam status_t ST_NX    = 4'b0001;

  logic               clk_i, rst_n_i;
  fp_t [2:0]          operands_i;      // c, b, a from MSB down
  op_e                op_i;
  logic               op_mod_i, in_valid_i, in_ready_o;
  logic [TAG_W-1:0]   tag_i, tag_o;
  fp_t                result_o;
  status_t            status_o;
  logic               out_valid_o, out_ready_i;

  int               seed = 32'he49e;
  int               checks, mismatches, timeouts;
  logic [TAG_W-1:0] next_tag;

  fma_unit #(.TagWidth(TAG_W)) dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  // ----------------------------------------------------------
  // Helpers and compare tasks
  // ----------------------------------------------------------
  // Exact binary16 pattern of an integer up to 2048, or 2052 and alike
  function automatic fp_t encode_int(input int value);
    fp_t enc;
    int  mag;
    int  msb;
    enc = '0;
    mag = (value < 0) ? -value : value;
    msb = 0;
    if (mag == 0) return POS_ZERO;
    for (int i = 0; i < 16; i++) begin
      if (mag[i]) msb = i;
    end
    enc.sign     = (value < 0);
    enc.exponent = EXP_BITS'(msb + BIAS);
    if (msb <= MAN_BITS) enc.mantissa = MAN_BITS'(mag << (MAN_BITS - msb));  // Drops hidden bit
    else enc.mantissa = MAN_BITS'(mag >> (msb - MAN_BITS));
    return enc;
  endfunction

  function automatic int pick_signed(input int lo, input int hi);
    int mag;
    mag = lo + int'($unsigned($random(seed)) % (hi - lo + 1));
    return ($random(seed) & 1) ? -mag : mag;
  endfunction

  task automatic check_result(input string name, input fp_t got, input fp_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %s: result_o got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_status(input string name, input status_t got, input status_t exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %s: status_o got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_tag(input string name, input logic [TAG_W-1:0] got,
                           input logic [TAG_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %s: tag_o got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input string sig, input logic got,
                            input logic exp);
    checks++;
    if (got !== exp) begin
      mismatches++;
      $display("[FAIL] %s: %s got %h expected %h", name, sig, got, exp);
    end
  endtask

  // ----------------------------------------------------------
  // Handshake drivers
  // ----------------------------------------------------------
  task automatic push(input fp_t a, input fp_t b, input fp_t c, input op_e op,
                      input logic mod, input logic [TAG_W-1:0] tag);
    int waited;
    waited = 0;
    @(posedge clk_i);
    operands_i <= {c, b, a};
    op_i       <= op;
    op_mod_i   <= mod;
    tag_i      <= tag;
    in_valid_i <= 1'b1;
    @(negedge clk_i);
    while (!in_ready_o && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!in_ready_o) begin
      timeouts++;
      $display("Timeout: DUT never accepted item with tag %h", tag);
    end
    @(posedge clk_i);  // Transfer happens here
    in_valid_i <= 1'b0;
  endtask

  task automatic expect_output(input string name, input fp_t exp_res, input status_t exp_st,
                               input logic [TAG_W-1:0] exp_tag);
    int waited;
    waited = 0;
    @(posedge clk_i);
    out_ready_i <= 1'b1;
    @(negedge clk_i);
    while (!out_valid_o && waited < TIMEOUT_CYCLES) begin
      @(negedge clk_i);
      waited++;
    end
    if (!out_valid_o) begin
      timeouts++;
      $display("Timeout: no output arrived for %s", name);
    end else begin
      check_result(name, result_o, exp_res);
      check_status(name, status_o, exp_st);
      check_tag(name, tag_o, exp_tag);
    end
    @(posedge clk_i);  // Item leaves on this edge
    out_ready_i <= 1'b0;
  endtask

  task automatic run_case(input string name, input fp_t a, input fp_t b, input fp_t c,
                          input op_e op, input logic mod, input fp_t exp_res,
                          input status_t exp_st);
    logic [TAG_W-1:0] tag;
    tag      = next_tag;
    next_tag = next_tag + 1'b1;  // Wraps, still distinct per item
    push(a, b, c, op, mod, tag);
    expect_output(name, exp_res, exp_st, tag);
  endtask

  // ----------------------------------------------------------
  // Directed tests
  // ----------------------------------------------------------
  task automatic fused_forms_test();
    int a, b, c;
    for (int n = 0; n < 8; n++) begin
      a = pick_signed(1, 32);    // |a*b| + |c| stays within 2048
      b = pick_signed(1, 32);
      c = pick_signed(1, 1024);
      run_case($sformatf("FMADD %0d*%0d+%0d", a, b, c), encode_int(a), encode_int(b),
               encode_int(c), FMADD, 1'b0, encode_int(a * b + c), ST_NONE);
      run_case($sformatf("FMSUB %0d*%0d-%0d", a, b, c), encode_int(a), encode_int(b),
               encode_int(c), FMADD, 1'b1, encode_int(a * b - c), ST_NONE);
      run_case($sformatf("FNMSUB -%0d*%0d+%0d", a, b, c), encode_int(a), encode_int(b),
               encode_int(c), FNMSUB, 1'b0, encode_int(-a * b + c), ST_NONE);
      run_case($sformatf("FNMADD -%0d*%0d-%0d", a, b, c), encode_int(a), encode_int(b),
               encode_int(c), FNMSUB, 1'b1, encode_int(-a * b - c), ST_NONE);
    end
  endtask

  task automatic add_sub_mul_test();
    // Operand a is a don't-care for ADD and SUB
    run_case("ADD 100+27", encode_int(9), encode_int(100), encode_int(27), ADD, 1'b0,
             encode_int(127), ST_NONE);
    run_case("SUB 100-27", encode_int(9), encode_int(100), encode_int(27), ADD, 1'b1,
             encode_int(73), ST_NONE);
    run_case("SUB 50-50", encode_int(9), encode_int(50), encode_int(50), ADD, 1'b1,
             POS_ZERO, ST_NONE);                                  // Cancellation gives +0
    run_case("ADD -7+7", encode_int(9), encode_int(-7), encode_int(7), ADD, 1'b0,
             POS_ZERO, ST_NONE);
    run_case("MUL 12*-11", encode_int(12), encode_int(-11), encode_int(5), MUL, 1'b0,
             encode_int(-132), ST_NONE);
    run_case("MUL -3*4", encode_int(-3), encode_int(4), encode_int(5), MUL, 1'b0,
             encode_int(-12), ST_NONE);
  endtask

  task automatic special_case_test();
    run_case("inf*0+1", POS_INF, POS_ZERO, encode_int(1), FMADD, 1'b0, QNAN, ST_NV);
    run_case("sNaN*1+1", 16'h7D00, encode_int(1), encode_int(1), FMADD, 1'b0, QNAN, ST_NV);
    run_case("qNaN*1+1", 16'hFE01, encode_int(1), encode_int(1), FMADD, 1'b0, QNAN,
             ST_NONE);                                            // Payload is dropped
    run_case("inf*1-inf", POS_INF, encode_int(1), POS_INF, FMADD, 1'b1, QNAN, ST_NV);
    run_case("inf*2+1", POS_INF, encode_int(2), encode_int(1), FMADD, 1'b0, POS_INF,
             ST_OFNX);
  endtask

  task automatic rounding_test();
    run_case("2048*1+1", encode_int(2048), encode_int(1), encode_int(1), FMADD, 1'b0,
             encode_int(2048), ST_NX);                            // Tie goes to even
    run_case("2048*1+3", encode_int(2048), encode_int(1), encode_int(3), FMADD, 1'b0,
             encode_int(2052), ST_NX);
    run_case("256*256+0", encode_int(256), encode_int(256), POS_ZERO, FMADD, 1'b0,
             POS_INF, ST_OFNX);                                   // Above 65504
  endtask

  task automatic backpressure_test();
    push(encode_int(3), encode_int(5), encode_int(1), FMADD, 1'b0, 4'hA);
    @(posedge clk_i);
    operands_i <= {encode_int(5), encode_int(9), encode_int(7)};  // Second item waits
    op_i       <= MUL;
    op_mod_i   <= 1'b0;
    tag_i      <= 4'h5;
    in_valid_i <= 1'b1;
    repeat (3) begin
      @(negedge clk_i);
      check_flag("held item", "in_ready_o", in_ready_o, 1'b0);
      check_flag("held item", "out_valid_o", out_valid_o, 1'b1);
      check_result("held item", result_o, encode_int(16));
      check_tag("held item", tag_o, 4'hA);
    end
    fork
      begin
        push(encode_int(7), encode_int(9), encode_int(5), MUL, 1'b0, 4'h5);
        push(encode_int(1), encode_int(100), encode_int(-28), ADD, 1'b0, 4'hC);
      end
      begin
        expect_output("burst item 1", encode_int(16), ST_NONE, 4'hA);
        expect_output("burst item 2", encode_int(63), ST_NONE, 4'h5);
        expect_output("burst item 3", encode_int(72), ST_NONE, 4'hC);
      end
    join
  endtask

  // ----------------------------------------------------------
  // Sequence
  // ----------------------------------------------------------
  initial begin
    operands_i  = '0;
    op_i        = FMADD;
    op_mod_i    = 1'b0;
    tag_i       = '0;
    in_valid_i  = 1'b0;
    out_ready_i = 1'b0;
    rst_n_i     = 1'b0;
    checks      = 0;
    mismatches  = 0;
    timeouts    = 0;
    next_tag    = '0;
    repeat (3) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(negedge clk_i);
    check_flag("after reset", "out_valid_o", out_valid_o, 1'b0);
    check_flag("after reset", "in_ready_o", in_ready_o, 1'b1);

    fused_forms_test();
    add_sub_mul_test();
    special_case_test();
    rounding_test();
    backpressure_test();

    repeat (2) @(posedge clk_i);
    $display("Summary: %0d checks, %0d mismatches, %0d timeouts", checks, mismatches,
             timeouts);
    if (mismatches == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- fma_unit.f
design/fma_pkg.sv
design/fma_operand_prep.sv
design/fma_product_path.sv
design/fma_addend_align.sv
design/fma_special_case.sv
design/fma_normalize_round.sv
design/fma_unit.sv
tests/tb_fma_unit.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal
TOP       := tb_fma_unit
FILELIST  := fma_unit.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
